// File: hw/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ====================
// Datapath widths
// ====================

`define XLEN        32
`define REG_ADDR_W  5

// ====================
// Reset and fill values
// ====================

// First fetch address
`define RESET_PC    32'h0000_0000

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

`endif

// File: hw/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    // ====================
    // Encodings
    // ====================

    // Opcodes the core understands
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // ====================
    // Pipeline registers
    // ====================

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  inst;
    } if_id_t;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src;   // Immediate as operand b
        logic    auipc;     // PC as operand a
        logic    lui;
        logic    branch;
        logic    branch_ne; // BNE when set, BEQ otherwise
        logic    jal;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rdata1;
        logic [`XLEN-1:0]       rdata2;
        logic [`XLEN-1:0]       imm;
        ctrl_t                  ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write;
        logic [`XLEN-1:0]       result;   // ALU, PC + 4 or immediate
        logic                   taken;    // Redirect fetch
        logic [`XLEN-1:0]       target;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write;
        logic [`XLEN-1:0]       result;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rv_alu.sv
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
    input  rv_pkg::alu_op_e         op_i,
    input  wire logic [`XLEN-1:0]   a_i,
    input  wire logic [`XLEN-1:0]   b_i,
    output logic [`XLEN-1:0]        result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_pkg::ALU_AND:  result_o = a_i & b_i;
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            // Compares give a single bit
            rv_pkg::ALU_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            end
            rv_pkg::ALU_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, a_i < b_i};
            end
            default:          result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_decoder.sv
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
    input  wire logic [`XLEN-1:0]       inst_i,
    output rv_pkg::ctrl_t               ctrl_o,
    output logic [`XLEN-1:0]            imm_o,
    output logic [`REG_ADDR_W-1:0]      rs1_o,
    output logic [`REG_ADDR_W-1:0]      rs2_o,
    output logic [`REG_ADDR_W-1:0]      rd_o
);

    logic [2:0]        funct3;
    logic              f7_5;
    logic              alt;      // Selects SUB or SRA
    logic [`XLEN-1:0]  imm_i_fmt;
    logic [`XLEN-1:0]  imm_u_fmt;
    logic [`XLEN-1:0]  imm_b_fmt;
    logic [`XLEN-1:0]  imm_j_fmt;
    rv_pkg::alu_op_e   alu_op_f3;

    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign rd_o   = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign f7_5   = inst_i[30];

    // Immediate formats
    assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_fmt = {inst_i[31:12], 12'b0};
    assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    // Immediate forms only use bit 30 for srai
    assign alt = (inst_i[6:0] == rv_pkg::OPC_OP) ? f7_5 : (f7_5 && funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  alu_op_f3 = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_op_f3 = rv_pkg::ALU_SLL;
            3'b010:  alu_op_f3 = rv_pkg::ALU_SLT;
            3'b011:  alu_op_f3 = rv_pkg::ALU_SLTU;
            3'b100:  alu_op_f3 = rv_pkg::ALU_XOR;
            3'b101:  alu_op_f3 = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_op_f3 = rv_pkg::ALU_OR;
            default: alu_op_f3 = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (rv_pkg::opcode_e'(inst_i[6:0]))
            rv_pkg::OPC_OP: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = alu_op_f3;
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_op    = alu_op_f3;
                imm_o            = imm_i_fmt;
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.lui       = 1'b1;
                imm_o            = imm_u_fmt;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.auipc     = 1'b1;
                ctrl_o.alu_src   = 1'b1;   // pc + imm through the ALU
                imm_o            = imm_u_fmt;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl_o.branch    = (funct3[2:1] == 2'b00); // BEQ and BNE only
                ctrl_o.branch_ne = funct3[0];
                imm_o            = imm_b_fmt;
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.jal       = 1'b1;
                imm_o            = imm_j_fmt;
            end
            default: ;  // Unknown opcode acts as a bubble
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_reg_file.sv
`default_nettype none

`include "rv_defs.svh"

module rv_reg_file (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic [`REG_ADDR_W-1:0] raddr1_i,
    input  wire logic [`REG_ADDR_W-1:0] raddr2_i,
    input  wire logic [`REG_ADDR_W-1:0] waddr_i,
    input  wire logic                   we_i,
    input  wire logic [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]            rdata1_o,
    output logic [`XLEN-1:0]            rdata2_o
);

    logic [`XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-first read lets decode see the value being written back
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (we_i && waddr_i == addr)
            return wdata_i;
        else
            return regs[addr];
    endfunction

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`default_nettype none

`include "rv_defs.svh"

module rv_execute (
    input  rv_pkg::id_ex_t   id_ex_i,
    input  rv_pkg::mem_wb_t  mem_fwd_i,   // Result leaving the memory stage
    input  rv_pkg::mem_wb_t  wb_fwd_i,    // Result being written back
    output rv_pkg::ex_mem_t  ex_mem_o
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;
    logic             br_taken;

    // ====================
    // Forwarding
    // ====================

    // Memory stage wins over write-back
    function automatic logic [`XLEN-1:0] fwd_sel(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       rf_val
    );
        if (rs == '0)
            return rf_val;
        else if (mem_fwd_i.valid && mem_fwd_i.reg_write && mem_fwd_i.rd == rs)
            return mem_fwd_i.result;
        else if (wb_fwd_i.valid && wb_fwd_i.reg_write && wb_fwd_i.rd == rs)
            return wb_fwd_i.result;
        else
            return rf_val;
    endfunction

    assign rs1_val = fwd_sel(id_ex_i.rs1, id_ex_i.rdata1);
    assign rs2_val = fwd_sel(id_ex_i.rs2, id_ex_i.rdata2);

    // ====================
    // ALU and branch
    // ====================

    assign alu_a = id_ex_i.ctrl.auipc   ? id_ex_i.pc  : rs1_val;
    assign alu_b = id_ex_i.ctrl.alu_src ? id_ex_i.imm : rs2_val;

    rv_alu alu_i (
        .op_i     (id_ex_i.ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_res)
    );

    assign br_taken = id_ex_i.ctrl.branch & ((rs1_val == rs2_val) ^ id_ex_i.ctrl.branch_ne);
    assign pc_plus4 = id_ex_i.pc + `XLEN'd4;

    always_comb begin
        ex_mem_o.valid     = id_ex_i.valid;
        ex_mem_o.rd        = id_ex_i.rd;
        ex_mem_o.reg_write = id_ex_i.ctrl.reg_write;
        ex_mem_o.taken     = id_ex_i.valid & (br_taken | id_ex_i.ctrl.jal);
        ex_mem_o.target    = id_ex_i.pc + id_ex_i.imm;  // Branch and JAL share it
        if (id_ex_i.ctrl.lui)
            ex_mem_o.result = id_ex_i.imm;
        else if (id_ex_i.ctrl.jal)
            ex_mem_o.result = pc_plus4;  // Link address
        else
            ex_mem_o.result = alu_res;
    end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`default_nettype none

`include "rv_defs.svh"

module rv_core (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    output logic [`XLEN-1:0]            pc_o,
    input  wire logic [`XLEN-1:0]       inst_i,
    output logic                        retire_valid_o,
    output logic [`REG_ADDR_W-1:0]      retire_rd_o,
    output logic [`XLEN-1:0]            retire_data_o
);

    localparam rv_pkg::if_id_t IF_ID_CLR = '{valid: 1'b0, pc: '0, inst: `NOP_INST};

    logic [`XLEN-1:0]        pc_q;
    logic [`XLEN-1:0]        pc_plus4;
    logic [`XLEN-1:0]        pc_next;
    logic                    flush;     // Taken branch or JAL in memory stage
    logic                    rf_we;

    rv_pkg::if_id_t          if_id_d,  if_id_q;
    rv_pkg::id_ex_t          id_ex_d,  id_ex_q;
    rv_pkg::ex_mem_t         ex_mem_d, ex_mem_q;
    rv_pkg::mem_wb_t         mem_wb_d, mem_wb_q;

    rv_pkg::ctrl_t           dec_ctrl;
    logic [`XLEN-1:0]        dec_imm;
    logic [`REG_ADDR_W-1:0]  dec_rs1, dec_rs2, dec_rd;
    logic [`XLEN-1:0]        rf_rdata1, rf_rdata2;

    // ====================
    // Fetch
    // ====================

    assign flush    = ex_mem_q.valid & ex_mem_q.taken;
    assign pc_plus4 = pc_q + `XLEN'd4;
    assign pc_next  = flush ? ex_mem_q.target : pc_plus4;
    assign pc_o     = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i)
            pc_q <= `RESET_PC;
        else
            pc_q <= pc_next;
    end

    assign if_id_d = '{valid: 1'b1, pc: pc_q, inst: inst_i};

    always_ff @(posedge clk) begin
        if (rst_i || flush)
            if_id_q <= IF_ID_CLR;
        else
            if_id_q <= if_id_d;
    end

    // ====================
    // Decode
    // ====================

    rv_decoder decoder_i (
        .inst_i (if_id_q.inst),
        .ctrl_o (dec_ctrl),
        .imm_o  (dec_imm),
        .rs1_o  (dec_rs1),
        .rs2_o  (dec_rs2),
        .rd_o   (dec_rd)
    );

    rv_reg_file reg_file_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (dec_rs1),
        .raddr2_i (dec_rs2),
        .waddr_i  (mem_wb_q.rd),
        .we_i     (rf_we),
        .wdata_i  (mem_wb_q.result),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    assign id_ex_d = '{valid: if_id_q.valid, pc: if_id_q.pc, rs1: dec_rs1, rs2: dec_rs2,
                       rd: dec_rd, rdata1: rf_rdata1, rdata2: rf_rdata2, imm: dec_imm,
                       ctrl: dec_ctrl};

    always_ff @(posedge clk) begin
        if (rst_i || flush)
            id_ex_q <= '0;
        else
            id_ex_q <= id_ex_d;
    end

    // ====================
    // Execute
    // ====================

    rv_execute execute_i (
        .id_ex_i   (id_ex_q),
        .mem_fwd_i (mem_wb_d),
        .wb_fwd_i  (mem_wb_q),
        .ex_mem_o  (ex_mem_d)
    );

    always_ff @(posedge clk) begin
        if (rst_i || flush)
            ex_mem_q <= '0;
        else
            ex_mem_q <= ex_mem_d;
    end

    // ====================
    // Memory and write-back
    // ====================

    // Without data memory the stage result passes straight on
    assign mem_wb_d = '{valid: ex_mem_q.valid, rd: ex_mem_q.rd,
                        reg_write: ex_mem_q.valid & ex_mem_q.reg_write,
                        result: ex_mem_q.result};

    always_ff @(posedge clk) begin
        if (rst_i)
            mem_wb_q <= '0;
        else
            mem_wb_q <= mem_wb_d;  // Branch itself still retires
    end

    assign rf_we          = mem_wb_q.valid & mem_wb_q.reg_write;
    assign retire_valid_o = rf_we && (mem_wb_q.rd != '0);  // x0 writes are dropped
    assign retire_rd_o    = mem_wb_q.rd;
    assign retire_data_o  = mem_wb_q.result;

endmodule

`default_nettype wire

// File: bench/tb_rv_core.sv
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int ROM_WORDS    = 32;
    localparam int N_EXPECT     = 22;
    localparam int RETIRE_WAIT  = 20;   // Cycles allowed per retire

    logic                   clk;
    logic                   rst_i;
    logic [`XLEN-1:0]       pc_o;
    logic [`XLEN-1:0]       inst_i;
    logic                   retire_valid_o;
    logic [`REG_ADDR_W-1:0] retire_rd_o;
    logic [`XLEN-1:0]       retire_data_o;

    logic [`XLEN-1:0]       rom [0:ROM_WORDS-1];
    int                     prog_len;
    string                  exp_name [N_EXPECT];
    logic [`REG_ADDR_W-1:0] exp_rd   [N_EXPECT];
    logic [`XLEN-1:0]       exp_val  [N_EXPECT];
    int                     exp_len;
    bit                     test_ok;
    int                     pass_count;
    int                     fail_count;

    rv_core dut_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .pc_o           (pc_o),
        .inst_i         (inst_i),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction ROM that returns NOP past its end
    assign inst_i = (pc_o < 32'(ROM_WORDS * 4)) ? rom[pc_o[6:2]] : `NOP_INST;

    // ====================
    // Instruction encoding
    // ====================

    function automatic logic [31:0] op_imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] op_reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ====================
    // Tables
    // ====================

    task automatic add_inst(input logic [31:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic add_expect(input string name, input logic [4:0] rd, input logic [31:0] val);
        exp_name[exp_len] = name;
        exp_rd[exp_len]   = rd;
        exp_val[exp_len]  = val;
        exp_len++;
    endtask

    task automatic load_program();
        add_inst(op_imm_word(3'b000, 5'd1, 5'd0, 12'd5));            // 0x00 addi x1, x0, 5
        add_inst(op_imm_word(3'b000, 5'd2, 5'd0, 12'hffd));          // 0x04 addi x2, x0, -3
        add_inst(op_reg_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));      // 0x08 add
        add_inst(op_reg_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));      // 0x0c sub
        add_inst(op_reg_word(7'h20, 3'b101, 5'd5, 5'd2, 5'd1));      // 0x10 sra x5, x2, x1
        add_inst(op_reg_word(7'h00, 3'b010, 5'd6, 5'd2, 5'd1));      // 0x14 slt
        add_inst(op_reg_word(7'h00, 3'b011, 5'd7, 5'd2, 5'd1));      // 0x18 sltu
        add_inst(op_reg_word(7'h00, 3'b100, 5'd8, 5'd1, 5'd2));      // 0x1c xor
        add_inst(op_reg_word(7'h00, 3'b110, 5'd9, 5'd1, 5'd2));      // 0x20 or
        add_inst(op_reg_word(7'h00, 3'b111, 5'd10, 5'd1, 5'd2));     // 0x24 and
        add_inst(op_imm_word(3'b001, 5'd11, 5'd1, 12'd4));           // 0x28 slli
        add_inst(op_imm_word(3'b101, 5'd12, 5'd2, 12'd28));          // 0x2c srli
        add_inst(op_imm_word(3'b000, 5'd0, 5'd1, 12'd7));            // 0x30 addi x0, x1, 7
        add_inst(op_reg_word(7'h00, 3'b000, 5'd13, 5'd0, 5'd1));     // 0x34 add x13, x0, x1
        add_inst(upper_word(7'b0110111, 5'd14, 20'h12345));          // 0x38 lui
        add_inst(upper_word(7'b0010111, 5'd15, 20'h00001));          // 0x3c auipc
        add_inst(op_imm_word(3'b000, 5'd16, 5'd14, 12'h678));        // 0x40 addi x16, x14
        add_inst(branch_word(3'b000, 5'd1, 5'd1, 13'd16));           // 0x44 beq to 0x54
        add_inst(op_imm_word(3'b000, 5'd20, 5'd0, 12'd1));           // 0x48 skipped
        add_inst(op_imm_word(3'b000, 5'd21, 5'd0, 12'd2));           // 0x4c skipped
        add_inst(op_imm_word(3'b000, 5'd22, 5'd0, 12'd3));           // 0x50 skipped
        add_inst(branch_word(3'b001, 5'd1, 5'd1, 13'd16));           // 0x54 bne, not taken
        add_inst(op_imm_word(3'b000, 5'd17, 5'd0, 12'h011));         // 0x58
        add_inst(op_imm_word(3'b000, 5'd18, 5'd17, 12'd1));          // 0x5c
        add_inst(op_imm_word(3'b000, 5'd19, 5'd18, 12'd1));          // 0x60
        add_inst(jal_word(5'd23, 21'd12));                           // 0x64 jal to 0x70
        add_inst(op_imm_word(3'b000, 5'd20, 5'd0, 12'h055));         // 0x68 skipped
        add_inst(op_imm_word(3'b000, 5'd21, 5'd0, 12'h066));         // 0x6c skipped
        add_inst(op_imm_word(3'b000, 5'd24, 5'd23, 12'd1));          // 0x70 jump target
        add_inst(op_imm_word(3'b000, 5'd25, 5'd0, 12'hfff));         // 0x74 addi x25, x0, -1
    endtask

    // Register writes in retire order
    // x0 targets and branches leave no entry
    task automatic load_expected();
        add_expect("addi_pos",      5'd1,  32'h0000_0005);
        add_expect("addi_neg",      5'd2,  32'hffff_fffd);
        add_expect("add_fwd",       5'd3,  32'h0000_0002);
        add_expect("sub_bypass",    5'd4,  32'h0000_0008);
        add_expect("sra_neg",       5'd5,  32'hffff_ffff);
        add_expect("slt_mixed",     5'd6,  32'h0000_0001);
        add_expect("sltu_mixed",    5'd7,  32'h0000_0000);
        add_expect("xor",           5'd8,  32'hffff_fff8);
        add_expect("or",            5'd9,  32'hffff_fffd);
        add_expect("and",           5'd10, 32'h0000_0005);
        add_expect("slli",          5'd11, 32'h0000_0050);
        add_expect("srli",          5'd12, 32'h0000_000f);
        add_expect("x0_source",     5'd13, 32'h0000_0005);
        add_expect("lui",           5'd14, 32'h1234_5000);
        add_expect("auipc",         5'd15, 32'h0000_103c);
        add_expect("addi_after_lui", 5'd16, 32'h1234_5678);
        add_expect("bne_fallthru",  5'd17, 32'h0000_0011);
        add_expect("chain_mem",     5'd18, 32'h0000_0012);
        add_expect("chain_mem2",    5'd19, 32'h0000_0013);
        add_expect("jal_link",      5'd23, 32'h0000_0068);
        add_expect("jal_target",    5'd24, 32'h0000_0069);
        add_expect("addi_m1",       5'd25, 32'hffff_ffff);
    endtask

    // ====================
    // Checking
    // ====================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_ok) begin
            $display("[pass] %s", name);
            pass_count++;
        end else begin
            $display("[fail] %s", name);
            fail_count++;
        end
    endtask

    initial begin
        int waited;
        bit seen;
        rst_i      = 1'b1;
        prog_len   = 0;
        exp_len    = 0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = `NOP_INST;
        end
        load_program();
        load_expected();

        // Nothing retires while reset is held
        test_ok = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("reset.retire_valid", 32'd0, {31'd0, retire_valid_o});
        end
        rst_i = 1'b0;
        @(negedge clk);
        check_value("reset.first_pc", 32'h0000_0000, pc_o);
        finish_test("reset");

        for (int i = 0; i < exp_len; i++) begin
            test_ok = 1'b1;
            waited  = 0;
            seen    = 1'b0;
            while (!seen && waited < RETIRE_WAIT) begin
                @(negedge clk);
                if (retire_valid_o)
                    seen = 1'b1;
                else
                    waited++;
            end
            if (!seen) begin
                $display("Missing retire for %s: no register write within %0d cycles",
                         exp_name[i], RETIRE_WAIT);
                test_ok = 1'b0;
                finish_test(exp_name[i]);
                break;
            end
            check_value({exp_name[i], ".rd"}, {{(`XLEN-`REG_ADDR_W){1'b0}}, exp_rd[i]},
                        {{(`XLEN-`REG_ADDR_W){1'b0}}, retire_rd_o});
            check_value({exp_name[i], ".data"}, exp_val[i], retire_data_o);
            finish_test(exp_name[i]);
        end

        // Flushed or trailing instructions must stay silent
        test_ok = 1'b1;
        repeat (RETIRE_WAIT) begin
            @(negedge clk);
            if (retire_valid_o) begin
                $display("Extra retire: x%0d written with 0x%08h after the last expected write",
                         retire_rd_o, retire_data_o);
                test_ok = 1'b0;
            end
        end
        finish_test("no_extra_retire");

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Reset time plus a retire window per entry and for the closing check
    initial begin
        #((RESET_CYCLES + (N_EXPECT + 2) * RETIRE_WAIT) * CLK_PERIOD);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_reg_file.sv
hw/rv_execute.sv
hw/rv_core.sv
bench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_rv_core -o tb_rv_core

out=$(./obj_dir/tb_rv_core)
echo "$out"

# Exit status follows the search result
echo "$out" | grep -q "ALL TESTS PASSED"
